//--- div_checker.sv
// Testbench monitor for div_top, predicts each result by the RISC-V rules and checks handshake timing
`timescale 1ns/100ps

module div_checker #(
    parameter int XLEN = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  div_pkg::div_op_t op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic             ack,
    input  logic [XLEN-1:0]  result,
    output int               errors,
    output int               responses
);
    import div_pkg::*;

    // ack is set XLEN/2 + 3 edges after acceptance and sampled one edge later
    localparam int ACK_SEEN = XLEN / 2 + 4;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    // Observer phase 0 idle, 1 waiting for ack, 2 ack held
    int              phase;
    int              lat;
    div_op_t         op_c;
    logic [XLEN-1:0] a_c;
    logic [XLEN-1:0] b_c;
    logic [XLEN-1:0] want;
    logic [XLEN-1:0] held;

    // Reference for the four M-extension divide operations
    function automatic logic [XLEN-1:0] predict_result(div_op_t o, logic [XLEN-1:0] x,
                                                       logic [XLEN-1:0] y);
        logic signed [XLEN-1:0] sx;
        logic signed [XLEN-1:0] sy;
        logic                   ovf;
        sx  = x;
        sy  = y;
        ovf = (x == MOST_NEG) && (y == '1);
        // Divide by zero, quotient all ones, remainder is the dividend
        if (y == '0) begin
            return (o == OP_DIV || o == OP_DIVU) ? '1 : x;
        end
        case (o)
            OP_DIVU: return x / y;
            OP_REMU: return x % y;
            // Signed ops round toward zero, remainder keeps dividend sign
            OP_DIV:  return ovf ? MOST_NEG : XLEN'(sx / sy);
            default: return ovf ? '0 : XLEN'(sx % sy);
        endcase
    endfunction

    // Values sampled on each edge are the ones settled before it
    always @(posedge clk) begin
        if (rst) begin
            phase     = 0;
            lat       = 0;
            errors    = 0;
            responses = 0;
        end else begin
            case (phase)
                0: begin
                    if (ack) begin
                        errors++;
                        $display("** Error @ %0t: ack high with no request pending", $time);
                    end else if (req) begin
                        // Controller in IDLE takes the request on this edge
                        op_c  = op;
                        a_c   = a;
                        b_c   = b;
                        lat   = 0;
                        phase = 1;
                    end
                end
                1: begin
                    lat++;
                    if (ack) begin
                        responses++;
                        held  = result;
                        want  = predict_result(op_c, a_c, b_c);
                        phase = 2;
                        if (result !== want) begin
                            errors++;
                            $display("** Error @ %0t: op=%s a=%h b=%h expected %h got %h",
                                     $time, op_c.name(), a_c, b_c, want, result);
                        end
                        if (lat != ACK_SEEN) begin
                            errors++;
                            $display("** Error @ %0t: ack seen %0d edges after req, expected %0d",
                                     $time, lat, ACK_SEEN);
                        end
                    end
                end
                default: begin
                    // ack low here means the controller sits in RELEASE
                    if (!ack) begin
                        phase = 0;
                    end else if (result !== held) begin
                        errors++;
                        $display("** Error @ %0t: result moved under ack, expected %h got %h",
                                 $time, held, result);
                    end
                end
            endcase
        end
    end

endmodule

//--- div_handshake_ctrl.sv
// Four-phase req/ack sequencer that issues the divider core's single-cycle start and ack pulses
`timescale 1ns/100ps

module div_handshake_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic complete,
    output logic ack,
    output logic start,
    output logic core_ack
);
    import div_pkg::*;

    div_state_t state;
    div_state_t state_next;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                // Wait for the core to finish
                if (complete) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                // Hold result until the requester lets go
                if (!req) begin
                    state_next = ST_RELEASE;
                end
            end
            ST_RELEASE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // State and pulse registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            start    <= 1'b0;
            core_ack <= 1'b0;
        end else begin
            state    <= state_next;
            // One cycle after req is first seen
            start    <= (state == ST_IDLE) && req;
            // Clears the core's complete flag during RELEASE
            core_ack <= (state == ST_DONE) && !req;
        end
    end

    // Requester ack is a pure state decode
    assign ack = (state == ST_DONE);

endmodule

//--- div_operand_prep.sv
// Turns divide operands into unsigned magnitudes with sign and zero flags for the selected opcode
`timescale 1ns/100ps

module div_operand_prep #(
    parameter int XLEN = 32
) (
    input  div_pkg::div_op_t op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic [XLEN-1:0]  a_mag,
    output logic [XLEN-1:0]  b_mag,
    output logic             neg_q,
    output logic             neg_r,
    output logic             div_zero
);
    import div_pkg::*;

    logic is_signed;
    logic a_neg;
    logic b_neg;

    assign is_signed = op_is_signed(op);

    // Sign bits only count for DIV and REM
    assign a_neg = is_signed & a[XLEN-1];
    assign b_neg = is_signed & b[XLEN-1];

    // Two's complement magnitudes
    // Most negative value maps onto itself, read back as unsigned
    assign a_mag = a_neg ? (~a + XLEN'(1)) : a;
    assign b_mag = b_neg ? (~b + XLEN'(1)) : b;

    // Single zero test for the whole unit
    assign div_zero = (b == '0);

    // Quotient sign, kept off for divide by zero so all ones survive
    assign neg_q = (a_neg ^ b_neg) & ~div_zero;

    // Remainder follows the dividend
    assign neg_r = a_neg;

endmodule

//--- div_pkg.sv
// Shared opcode and state types plus default width for the RISC-V divide unit, imported by RTL and testbench

package div_pkg;

    // Operand width handed to div_top when the top level does not override it
    // Must stay even, the core retires two quotient bits per cycle
    localparam int DIV_XLEN_DEFAULT = 32;

    // Divide opcodes
    // Encoding follows the low two funct3 bits of the M extension
    //   100 DIV, 101 DIVU, 110 REM, 111 REMU
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_t;

    // Requester handshake states
    // IDLE waits for req, RUN waits for the core,
    // DONE holds ack until req drops, RELEASE clears the core
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_RUN     = 2'b01,
        ST_DONE    = 2'b10,
        ST_RELEASE = 2'b11
    } div_state_t;

    // Opcode class helpers
    function automatic logic op_is_signed(div_op_t op);
        return (op == OP_DIV) || (op == OP_REM);
    endfunction

    function automatic logic op_is_rem(div_op_t op);
        return (op == OP_REM) || (op == OP_REMU);
    endfunction

endpackage

//--- div_radix4.sv
// Iterative unsigned radix-4 restoring divider started by a pulse, with complete held until ack
`timescale 1ns/100ps

module div_radix4 #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            ack,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] q,
    output logic [XLEN-1:0] r,
    output logic            complete
);

    // Two quotient bits per iteration
    localparam int ITER  = XLEN / 2;
    localparam int CNT_W = $clog2(ITER + 1);

    logic             running;
    logic [CNT_W-1:0] count;

    // Partial remainder and divisor multiples are two bits wider than the operands
    logic [XLEN+1:0] pr;
    logic [XLEN+1:0] b_1;
    logic [XLEN+1:0] b_2;
    logic [XLEN+1:0] b_3;

    // Trial subtractions with the borrow in the top bit
    logic [XLEN+2:0] pr_sub_1;
    logic [XLEN+2:0] pr_sub_2;
    logic [XLEN+2:0] pr_sub_3;

    assign pr_sub_1 = {1'b0, pr} - {1'b0, b_1};
    assign pr_sub_2 = {1'b0, pr} - {1'b0, b_2};
    assign pr_sub_3 = {1'b0, pr} - {1'b0, b_3};

    // Divisor multiples, partial remainder and quotient shift register
    always_ff @(posedge clk) begin
        if (start) begin
            b_1 <= {2'b00, b};
            b_2 <= {1'b0, b, 1'b0};
            b_3 <= {1'b0, b, 1'b0} + {2'b00, b};
            // Top dividend pair seeds the remainder while the rest waits in q
            pr  <= {{XLEN{1'b0}}, a[XLEN-1 -: 2]};
            q   <= {a[XLEN-3:0], 2'b00};
        end else if (running && (count != CNT_W'(ITER))) begin
            // Largest multiple that does not borrow wins
            if (!pr_sub_3[XLEN+2]) begin
                pr <= {pr_sub_3[XLEN-1:0], q[XLEN-1 -: 2]};
                q  <= {q[XLEN-3:0], 2'b11};
            end else if (!pr_sub_2[XLEN+2]) begin
                pr <= {pr_sub_2[XLEN-1:0], q[XLEN-1 -: 2]};
                q  <= {q[XLEN-3:0], 2'b10};
            end else if (!pr_sub_1[XLEN+2]) begin
                pr <= {pr_sub_1[XLEN-1:0], q[XLEN-1 -: 2]};
                q  <= {q[XLEN-3:0], 2'b01};
            end else begin
                pr <= {pr[XLEN-1:0], q[XLEN-1 -: 2]};
                q  <= {q[XLEN-3:0], 2'b00};
            end
        end
    end

    // Last shift brings in two padding zeros that are dropped here
    assign r = pr[XLEN+1:2];

    // Iteration counter and completion flag
    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            count    <= '0;
            complete <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            count    <= '0;
            complete <= 1'b0;
        end else if (running) begin
            if (count == CNT_W'(ITER)) begin
                // All digits retired so q and pr freeze
                running  <= 1'b0;
                complete <= 1'b1;
            end else begin
                count <= count + CNT_W'(1);
            end
        end else if (ack) begin
            complete <= 1'b0;
        end
    end

endmodule

//--- div_result_fix.sv
// Reapplies signs to the core outputs and picks quotient or remainder as the divide result
`timescale 1ns/100ps

module div_result_fix #(
    parameter int XLEN = 32
) (
    input  div_pkg::div_op_t op,
    input  logic [XLEN-1:0]  q,
    input  logic [XLEN-1:0]  r,
    input  logic             neg_q,
    input  logic             neg_r,
    input  logic             div_zero,
    output logic [XLEN-1:0]  result
);
    import div_pkg::*;

    logic [XLEN-1:0] q_signed;
    logic [XLEN-1:0] r_signed;
    logic [XLEN-1:0] q_final;

    // Negate toward zero rounding
    assign q_signed = neg_q ? (~q + XLEN'(1)) : q;
    assign r_signed = neg_r ? (~r + XLEN'(1)) : r;

    // Divide by zero forces an all ones quotient
    // Core already yields this unsigned and neg_q stays off for signed ops
    assign q_final = div_zero ? '1 : q_signed;

    // MIN / -1 falls out naturally
    // |MIN| / 1 is 2^(XLEN-1) which negates back to MIN with a zero remainder

    // Remainder for REM and REMU and quotient for DIV and DIVU
    assign result = op_is_rem(op) ? r_signed : q_final;

endmodule

//--- div_top.sv
// Top of the RISC-V M-extension divide unit, one division per four-phase req/ack exchange
`timescale 1ns/100ps

module div_top #(
    parameter int XLEN = div_pkg::DIV_XLEN_DEFAULT
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  div_pkg::div_op_t op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic             ack,
    output logic [XLEN-1:0]  result
);

    // Operand prep to core and fixup
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;

    // Core control and outputs
    logic            start;
    logic            core_ack;
    logic            complete;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;

    div_handshake_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .complete (complete),
        .ack      (ack),
        .start    (start),
        .core_ack (core_ack)
    );

    // Inputs held by the requester, so flags stay valid all run
    div_operand_prep #(.XLEN(XLEN)) u_prep (
        .op       (op),
        .a        (a),
        .b        (b),
        .a_mag    (a_mag),
        .b_mag    (b_mag),
        .neg_q    (neg_q),
        .neg_r    (neg_r),
        .div_zero (div_zero)
    );

    div_radix4 #(.XLEN(XLEN)) u_core (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .ack      (core_ack),
        .a        (a_mag),
        .b        (b_mag),
        .q        (q),
        .r        (r),
        .complete (complete)
    );

    div_result_fix #(.XLEN(XLEN)) u_fix (
        .op       (op),
        .q        (q),
        .r        (r),
        .neg_q    (neg_q),
        .neg_r    (neg_r),
        .div_zero (div_zero),
        .result   (result)
    );

endmodule

//--- div_top_sva.sv
// Handshake assertions for div_top that the testbench top attaches by bind
`timescale 1ns/100ps

module div_top_sva (
    input logic                clk,
    input logic                rst,
    input logic                req,
    input logic                ack,
    input logic                start,
    input logic                complete,
    input div_pkg::div_state_t state
);
    import div_pkg::*;

    // Failed assertion count for the testbench verdict
    int failures = 0;

    // ack only answers a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else begin
            failures++;
            $error("ack rose while req was low");
        end

    // No early release of ack
    ack_holds: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
        else begin
            failures++;
            $error("ack dropped while req still high");
        end

    start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
        else begin
            failures++;
            $error("core start longer than one cycle");
        end

    // Stale completion would end the next run early
    no_stale_complete: assert property (@(posedge clk) disable iff (rst) !(start && complete))
        else begin
            failures++;
            $error("core complete high during start");
        end

    // Core ack has cleared complete by the time the controller is back in IDLE
    idle_complete_clear: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !complete)
        else begin
            failures++;
            $error("core complete still high in IDLE");
        end

endmodule

//--- sim.f
div_pkg.sv
div_radix4.sv
div_operand_prep.sv
div_result_fix.sv
div_handshake_ctrl.sv
div_top.sv
div_checker.sv
div_top_sva.sv
tb_div_top.sv

//--- tb_div_top.sv
// Testbench for div_top driving random DIV/DIVU/REM/REMU requests over the four-phase handshake
`timescale 1ns/100ps

module tb_div_top;
    import div_pkg::*;

    localparam int XLEN    = 32;
    localparam int NUM_REQ = 400;
    localparam int TIMEOUT = 100;

    logic            clk;
    logic            rst;
    logic            req;
    div_op_t         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            ack;
    logic [XLEN-1:0] result;
    logic [31:0]     rng;
    int              mismatches;
    int              responses;
    int              timeouts;

    div_top #(.XLEN(XLEN)) dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result)
    );

    div_checker #(.XLEN(XLEN)) u_checker (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .op        (op),
        .a         (a),
        .b         (b),
        .ack       (ack),
        .result    (result),
        .errors    (mismatches),
        .responses (responses)
    );

    bind div_top div_top_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .start    (start),
        .complete (complete),
        .state    (u_ctrl.state)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // xorshift32 step on the shared generator state
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // One edge at a time until ack reaches level or the limit runs out
    task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (ack !== level && cycles < TIMEOUT);
        if (ack !== level) begin
            timeouts++;
            $display("Timeout: ack did not %s within %0d cycles", what, TIMEOUT);
        end
    endtask

    task automatic pick_operands();
        logic [31:0] r;
        r  = next_random();
        op = div_op_t'(r[1:0]);
        a  = next_random();
        b  = next_random();
        // Shrunk dividend gives small quotients
        if (r[4:3] == 2'b00) a = $signed(a) >>> r[9:5];
        // Shrunk divisor gives large quotients
        if (r[11:10] == 2'b00) b = $signed(b) >>> (5'd16 + r[14:12]);
        if (r[17:15] == 3'b000) begin
            b = '0;
        end else if (r[22:18] == 5'b00000) begin
            // Signed overflow corner
            a  = {1'b1, {(XLEN-1){1'b0}}};
            b  = '1;
            op = r[23] ? OP_DIV : OP_REM;
        end
    endtask

    initial begin
        int          n;
        logic [31:0] r;
        rst      = 1'b1;
        req      = 1'b0;
        op       = OP_DIV;
        a        = '0;
        b        = '0;
        timeouts = 0;
        rng      = 32'h5fd05b15;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (n = 0; n < NUM_REQ; n++) begin
            r = next_random();
            // Gap of zero gives back-to-back requests
            repeat (r[1:0]) begin
                @(posedge clk);
                #1;
            end
            pick_operands();
            req = 1'b1;
            wait_ack(1'b1, "rise");
            // Late release holds the unit in DONE
            repeat (r[3:2]) begin
                @(posedge clk);
                #1;
            end
            req = 1'b0;
            wait_ack(1'b0, "fall");
        end
        repeat (4) @(posedge clk);
        $display("Requests %0d, responses %0d, mismatches %0d, timeouts %0d, assertions %0d",
                 NUM_REQ, responses, mismatches, timeouts, dut.u_sva.failures);
        if (mismatches == 0 && timeouts == 0 && dut.u_sva.failures == 0 &&
            responses == NUM_REQ) begin
            $display("TESTBENCH PASSED");
        end else begin
            if (responses != NUM_REQ) begin
                $display("Number of responses differs from the number of requests");
            end
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
